//--- design/video_cfg_pkg.sv
// video format types; widths fixed by the 448x320 raster, no gigascreen addressing
package video_cfg_pkg;

	// video modes as written to vconf[2:0]
	typedef enum logic [2:0] {
		mode_zx    = 3'd0,
		mode_16c   = 3'd1,
		mode_256c  = 3'd2,
		mode_text  = 3'd3,
		mode_giga  = 3'd4,
		mode_zxhi  = 3'd5,
		mode_rsvd  = 3'd6,
		mode_nogfx = 3'd7
	} vmode_t;

	typedef enum logic [1:0] {
		rend_zx,
		rend_16c,
		rend_256c,
		rend_text
	} rmode_t;

	typedef logic [1:0] rres_t;        // 256x192, 320x200, 320x240, 360x288
	typedef logic [8:0] raster_pos_t;
	typedef logic [7:0] col_t;
	typedef logic [5:0] tiles_t;

	localparam raster_pos_t line_len  = 9'd448;  // pixels per line incl. blanking
	localparam raster_pos_t frame_len = 9'd320;  // lines per frame

	localparam logic [3:0] fsel_char = 4'b0011;  // fetch_sel code of a text char fetch

endpackage

//--- design/video_bus_pkg.sv
// bus widths and register map; registers are 8 bits on a 3-bit word address
package video_bus_pkg;

	typedef logic [7:0]  wb_data_t;
	typedef logic [2:0]  wb_addr_t;
	typedef logic [20:0] dram_addr_t;
	typedef logic [15:0] dram_data_t;
	typedef logic [3:0]  bw_t;

	// mode in [2:0], resolution in [7:6]
	localparam wb_addr_t reg_vconf    = 3'd0;
	localparam wb_addr_t reg_vpage    = 3'd1;
	localparam wb_addr_t reg_xoffs_lo = 3'd2;
	// bit 0 only, x offset bit 8
	localparam wb_addr_t reg_xoffs_hi = 3'd3;
	// bit 0 overrun, sticky until written
	localparam wb_addr_t reg_status   = 3'd4;

endpackage

//--- design/video_regs.sv
// wishbone classic slave, ack one cycle after cyc&stb; master must hold the bus until ack
`timescale 1ns/1ps

module video_regs
	import video_bus_pkg::*;
(
	input  logic     clk,
	input  logic     rst_n,
	input  logic     wb_cyc,
	input  logic     wb_stb,
	input  logic     wb_we,
	input  wb_addr_t wb_adr,
	input  wb_data_t wb_dat_w,
	output wb_data_t wb_dat_r,
	output logic     wb_ack,
	input  logic     overrun_set,
	output wb_data_t vconf,
	output wb_data_t vpage,
	output logic [8:0] x_offs
);

	logic ack;
	logic overrun;
	logic acc;
	logic wr;

	assign acc = wb_cyc & wb_stb & ~ack;  // new access, not the one being acked
	assign wr = acc & wb_we;
	assign wb_ack = ack;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			ack <= 1'b0;
			vconf <= '0;
			vpage <= '0;
			x_offs <= '0;
			overrun <= 1'b0;
		end else begin
			ack <= acc;
			if (wr) begin
				case (wb_adr)
					reg_vconf:    vconf <= wb_dat_w;
					reg_vpage:    vpage <= wb_dat_w;
					reg_xoffs_lo: x_offs[7:0] <= wb_dat_w;
					reg_xoffs_hi: x_offs[8] <= wb_dat_w[0];
					reg_status:   overrun <= 1'b0;  // any write clears
					default: ;
				endcase
			end
			if (overrun_set)
				overrun <= 1'b1;  // a new overrun beats the clear
		end
	end

	// read mux, address is held while ack is high
	always_comb begin
		case (wb_adr)
			reg_vconf:    wb_dat_r = vconf;
			reg_vpage:    wb_dat_r = vpage;
			reg_xoffs_lo: wb_dat_r = x_offs[7:0];
			reg_xoffs_hi: wb_dat_r = {7'd0, x_offs[8]};
			reg_status:   wb_dat_r = {7'd0, overrun};
			default:      wb_dat_r = '0;
		endcase
	end

endmodule

//--- design/video_mode.sv
// mode decoder tables; mode is sampled one clk after vconf, giga mode fetches address zero
`timescale 1ns/1ps

module video_mode
	import video_cfg_pkg::*;
	import video_bus_pkg::*;
(
	input  logic        clk,
	input  logic        f0,
	input  logic        q2,
	input  logic        c6,
	input  wb_data_t    vconf,
	input  wb_data_t    vpage,
	input  raster_pos_t x_offs,
	output logic [9:0]  x_offs_mode,
	output raster_pos_t hpix_beg,
	output raster_pos_t hpix_end,
	output raster_pos_t vpix_beg,
	output raster_pos_t vpix_end,
	output tiles_t      x_tiles,
	output logic [4:0]  go_offs,
	output logic [3:0]  fetch_sel,
	output logic [1:0]  fetch_bsl,
	input  logic [3:0]  fetch_cnt,
	input  dram_data_t  txt_char,
	input  col_t        cnt_col,
	input  raster_pos_t cnt_row,
	input  logic        cptr,
	input  logic        pix_start,
	output logic        hires,
	output rmode_t      render_mode,
	output logic        nogfx,
	output logic        pix_stb,
	output logic        fetch_stb,
	output dram_addr_t  video_addr,
	output bw_t         video_bw
);

	vmode_t vmod;
	rres_t rres;
	logic ftch;
	logic [11:0] addr_zx_gfx;
	logic [11:0] addr_zx_atr;
	logic [13:0] addr_tx;
	dram_addr_t addr_zx;
	dram_addr_t addr_16c;
	dram_addr_t addr_256c;
	dram_addr_t addr_text;

	// registered copy keeps the wb write path out of the table decode
	always_ff @(posedge clk) begin
		vmod <= vmode_t'(vconf[2:0]);
		rres <= vconf[7:6];
	end

	assign nogfx = (vmod == mode_nogfx);
	assign hires = (vmod == mode_text) || (vmod == mode_zxhi);
	assign pix_stb = hires ? f0 : q2;
	assign x_offs_mode = {(vmod == mode_256c) ? {x_offs[8:1], 1'b0} : {1'b0, x_offs[8:1]},
		x_offs[0]};

	// per-mode tables
	always_comb begin
		case (vmod)
			mode_16c:  begin render_mode = rend_16c;  go_offs = 5'd10; video_bw = 4'b1010; end
			mode_256c: begin render_mode = rend_256c; go_offs = 5'd6;  video_bw = 4'b0010; end
			mode_text: begin render_mode = rend_text; go_offs = 5'd10; video_bw = 4'b1100; end
			mode_giga: begin render_mode = rend_zx;   go_offs = 5'd18; video_bw = 4'b1010; end
			mode_zxhi: begin render_mode = rend_zx;   go_offs = 5'd10; video_bw = 4'b1010; end
			default:   begin render_mode = rend_zx;   go_offs = 5'd18; video_bw = 4'b1001; end
		endcase
	end

	// fetch period in c6 slots: 16, 8, 4, 16
	always_comb begin
		case (render_mode)
			rend_16c:  ftch = &fetch_cnt[2:0];
			rend_256c: ftch = &fetch_cnt[1:0];
			default:   ftch = &fetch_cnt[3:0];
		endcase
	end
	// the first strobe comes one period after pix_start clears fetch_cnt
	assign fetch_stb = ftch & c6;

	// cnt_col has already moved on when the data comes back
	always_comb begin
		if (vmod == mode_text) begin
			case (cnt_col[1:0])
				2'd1:    begin fetch_sel = fsel_char; fetch_bsl = 2'b10; end
				2'd2:    begin fetch_sel = 4'b1100;   fetch_bsl = 2'b10; end  // attr
				2'd3:    begin fetch_sel = 4'b0001;   fetch_bsl = {2{cnt_row[0]}}; end
				default: begin fetch_sel = 4'b0010;   fetch_bsl = {2{cnt_row[0]}}; end
			endcase
		end else begin
			fetch_sel = {~cptr, ~cptr, cptr, cptr};
			fetch_bsl = 2'b10;
		end
	end

	// raster window per resolution
	always_comb begin
		case (rres)
			2'd0: begin
				hpix_beg = 9'd140; hpix_end = 9'd396;
				vpix_beg = 9'd80;  vpix_end = 9'd272; x_tiles = 6'd33;
			end
			2'd1: begin
				hpix_beg = 9'd108; hpix_end = 9'd428;
				vpix_beg = 9'd76;  vpix_end = 9'd276; x_tiles = 6'd41;
			end
			2'd2: begin
				hpix_beg = 9'd108; hpix_end = 9'd428;
				vpix_beg = 9'd56;  vpix_end = 9'd296; x_tiles = 6'd41;
			end
			default: begin  // full 360x288 border-less
				hpix_beg = 9'd88;  hpix_end = 9'd448;
				vpix_beg = 9'd32;  vpix_end = 9'd320; x_tiles = 6'd46;
			end
		endcase
	end

	// zx screen layout, thirds then char line then pixel line
	assign addr_zx_gfx = {cnt_row[7:6], cnt_row[2:0], cnt_row[5:3], cnt_col[4:1]};
	assign addr_zx_atr = {3'b110, cnt_row[7:3], cnt_col[4:1]};
	assign addr_zx = {vpage, 1'b0, cnt_col[0] ? addr_zx_atr : addr_zx_gfx};

	assign addr_16c = {vpage[7:3], cnt_row, cnt_col[6:0]};
	assign addr_256c = {vpage[7:4], cnt_row, cnt_col};

	// text: char, attr, then both glyph bytes from the latched char word
	always_comb begin
		case (cnt_col[1:0])
			2'd0: addr_tx = {1'b0, cnt_row[8:3], 1'b0, cnt_col[7:2]};
			2'd1: addr_tx = {1'b0, cnt_row[8:3], 1'b1, cnt_col[7:2]};
			2'd2: addr_tx = {4'b1000, txt_char[7:0], cnt_row[2:1]};
			default: addr_tx = {4'b1000, txt_char[15:8], cnt_row[2:1]};
		endcase
	end
	assign addr_text = {vpage[7:1], addr_tx};

	always_comb begin
		case (vmod)
			mode_16c:  video_addr = addr_16c;
			mode_256c: video_addr = addr_256c;
			mode_text: video_addr = addr_text;
			mode_giga: video_addr = '0;
			default:   video_addr = addr_zx;
		endcase
	end

endmodule

//--- design/video_raster.sv
// raster counters in pixel units, one pixel per 4 clk; window limits come from the mode decoder
`timescale 1ns/1ps

module video_raster
	import video_cfg_pkg::*;
(
	input  logic        clk,
	input  logic        rst_n,
	input  raster_pos_t hpix_beg,
	input  raster_pos_t vpix_beg,
	input  raster_pos_t vpix_end,
	input  logic [4:0]  go_offs,
	output logic        f0,
	output logic        q2,
	output logic        c6,
	output raster_pos_t cnt_row,
	output logic        pix_start,
	output logic        frame_start
);

	logic [2:0] phase;
	raster_pos_t hcnt;
	raster_pos_t vcnt;
	raster_pos_t pstart;
	logic h_wrap;
	logic v_wrap;
	logic v_in;

	assign f0 = phase[0];
	assign q2 = (phase[1:0] == 2'b11);
	assign c6 = (phase == 3'd7);

	assign h_wrap = (hcnt == line_len - 9'd1);
	assign v_wrap = (vcnt == frame_len - 9'd1);

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			phase <= '0;
			hcnt <= '0;
			vcnt <= '0;
			frame_start <= 1'b0;
		end else begin
			phase <= phase + 3'd1;
			frame_start <= q2 & h_wrap & v_wrap;  // first clk of the new frame
			if (q2) begin
				if (h_wrap) begin
					hcnt <= '0;
					if (v_wrap)
						vcnt <= '0;
					else
						vcnt <= vcnt + 9'd1;
				end else begin
					hcnt <= hcnt + 9'd1;
				end
			end
		end
	end

	// fetch starts go_offs pixels ahead of the visible window
	assign pstart = hpix_beg - {4'd0, go_offs};
	assign v_in = (vcnt >= vpix_beg) && (vcnt < vpix_end);
	assign cnt_row = vcnt - vpix_beg;

	// hcnt steps twice per c6 slot and is odd at c6, so match on the pixel pair
	assign pix_start = c6 & v_in & (hcnt[8:1] == pstart[8:1]);

endmodule

//--- design/video_fetch.sv
// one outstanding dram read; strobes arriving while req is high are dropped as overrun
`timescale 1ns/1ps

module video_fetch
	import video_cfg_pkg::*;
	import video_bus_pkg::*;
(
	input  logic       clk,
	input  logic       rst_n,
	input  logic       c6,
	input  logic       pix_start,
	input  logic       fetch_stb,
	input  tiles_t     x_tiles,
	input  logic [3:0] fetch_sel,
	input  dram_addr_t video_addr,
	input  bw_t        video_bw,
	output logic [3:0] fetch_cnt,
	output col_t       cnt_col,
	output logic       cptr,
	output dram_data_t txt_char,
	output logic       dram_req,
	output dram_addr_t dram_addr,
	output bw_t        dram_bw,
	input  logic       dram_ack,
	input  dram_data_t dram_data,
	output logic       overrun_set
);

	logic issue;

	// only while the line still has columns left
	assign issue = fetch_stb & ~dram_req & (cnt_col < {2'b00, x_tiles});
	assign overrun_set = fetch_stb & dram_req;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			fetch_cnt <= '0;
			cnt_col <= '1;  // parked past the line until the first pix_start
			cptr <= 1'b0;
			dram_req <= 1'b0;
		end else begin
			if (pix_start)
				fetch_cnt <= '0;
			else if (c6)
				fetch_cnt <= fetch_cnt + 4'd1;

			if (pix_start) begin
				cnt_col <= '0;
				cptr <= 1'b0;
			end else if (issue) begin
				cnt_col <= cnt_col + 8'd1;
				cptr <= ~cptr;
			end

			if (issue)
				dram_req <= 1'b1;
			else if (dram_ack)
				dram_req <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (issue) begin
			dram_addr <= video_addr;
			dram_bw <= video_bw;
		end
		if (dram_req && dram_ack && fetch_sel == fsel_char)
			txt_char <= dram_data;  // glyph addresses are built from this
	end

endmodule

//--- design/video_top.sv
// video address and timing core, no pixel output; dram port serves a single client
`timescale 1ns/1ps

module video_top
	import video_cfg_pkg::*;
	import video_bus_pkg::*;
(
	input  logic       clk,
	input  logic       rst_n,
	input  logic       wb_cyc,
	input  logic       wb_stb,
	input  logic       wb_we,
	input  wb_addr_t   wb_adr,
	input  wb_data_t   wb_dat_w,
	output wb_data_t   wb_dat_r,
	output logic       wb_ack,
	output logic       dram_req,
	output dram_addr_t dram_addr,
	output bw_t        dram_bw,
	input  logic       dram_ack,
	input  dram_data_t dram_data,
	output rmode_t     render_mode,
	output logic       hires,
	output logic       nogfx,
	output logic       pix_stb,
	output logic [1:0] fetch_bsl,
	output logic       frame_start
);

	wb_data_t vconf;
	wb_data_t vpage;
	raster_pos_t x_offs;
	raster_pos_t hpix_beg;
	raster_pos_t vpix_beg;
	raster_pos_t vpix_end;
	raster_pos_t cnt_row;
	tiles_t x_tiles;
	col_t cnt_col;
	logic [4:0] go_offs;
	logic [3:0] fetch_sel;
	logic [3:0] fetch_cnt;
	dram_data_t txt_char;
	dram_addr_t video_addr;
	bw_t video_bw;
	logic f0;
	logic q2;
	logic c6;
	logic cptr;
	logic pix_start;
	logic fetch_stb;
	logic overrun_set;

	video_regs u_regs (
		.clk(clk), .rst_n(rst_n),
		.wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we), .wb_adr(wb_adr),
		.wb_dat_w(wb_dat_w), .wb_dat_r(wb_dat_r), .wb_ack(wb_ack),
		.overrun_set(overrun_set), .vconf(vconf), .vpage(vpage), .x_offs(x_offs)
	);

	// x_offs_mode and hpix_end belong to the renderer, not built here
	video_mode u_mode (
		.clk(clk), .f0(f0), .q2(q2), .c6(c6),
		.vconf(vconf), .vpage(vpage), .x_offs(x_offs), .x_offs_mode(),
		.hpix_beg(hpix_beg), .hpix_end(), .vpix_beg(vpix_beg), .vpix_end(vpix_end),
		.x_tiles(x_tiles), .go_offs(go_offs), .fetch_sel(fetch_sel), .fetch_bsl(fetch_bsl),
		.fetch_cnt(fetch_cnt), .txt_char(txt_char), .cnt_col(cnt_col), .cnt_row(cnt_row),
		.cptr(cptr), .pix_start(pix_start), .hires(hires), .render_mode(render_mode),
		.nogfx(nogfx), .pix_stb(pix_stb), .fetch_stb(fetch_stb),
		.video_addr(video_addr), .video_bw(video_bw)
	);

	video_raster u_raster (
		.clk(clk), .rst_n(rst_n),
		.hpix_beg(hpix_beg), .vpix_beg(vpix_beg), .vpix_end(vpix_end), .go_offs(go_offs),
		.f0(f0), .q2(q2), .c6(c6), .cnt_row(cnt_row),
		.pix_start(pix_start), .frame_start(frame_start)
	);

	video_fetch u_fetch (
		.clk(clk), .rst_n(rst_n), .c6(c6), .pix_start(pix_start),
		.fetch_stb(fetch_stb), .x_tiles(x_tiles), .fetch_sel(fetch_sel),
		.video_addr(video_addr), .video_bw(video_bw),
		.fetch_cnt(fetch_cnt), .cnt_col(cnt_col), .cptr(cptr), .txt_char(txt_char),
		.dram_req(dram_req), .dram_addr(dram_addr), .dram_bw(dram_bw),
		.dram_ack(dram_ack), .dram_data(dram_data), .overrun_set(overrun_set)
	);

endmodule

//--- bench/video_tb.sv
// directed bench for video_top; frame tests take about three frames, window rows assume res 0/1
`timescale 1ns/1ps

module video_tb
	import video_cfg_pkg::*;
	import video_bus_pkg::*;
();

	localparam int line_clks = int'(line_len) * 4;  // 4 clk per pixel
	localparam int frame_clks = line_clks * int'(frame_len);
	localparam int vbeg_res0 = 80;  // first window line at resolution 0

	logic       clk;
	logic       rst_n;
	logic       wb_cyc;
	logic       wb_stb;
	logic       wb_we;
	wb_addr_t   wb_adr;
	wb_data_t   wb_dat_w;
	wb_data_t   wb_dat_r;
	logic       wb_ack;
	logic       dram_req;
	dram_addr_t dram_addr;
	bw_t        dram_bw;
	logic       dram_ack;
	dram_data_t dram_data;
	rmode_t     render_mode;
	logic       hires;
	logic       nogfx;
	logic       pix_stb;
	logic [1:0] fetch_bsl;
	logic       frame_start;

	logic [31:0] lfsr = 32'h25252d5e;
	int errors = 0;
	int tests_run = 0;
	int tests_failed = 0;
	dram_addr_t req_addr_q[$];
	bw_t req_bw_q[$];
	logic hold_ack = 1'b0;
	logic char_armed = 1'b0;
	dram_addr_t char_addr = '0;
	dram_data_t char_word = '0;

	video_top uut (.*);

	initial clk = 1'b0;
	always #4 clk = ~clk;

	// galois form, one step per bit taken
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] r;
		r = '0;
		for (int i = 0; i < n; i++) begin
			r = {r[30:0], lfsr[0]};
			lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'hd0000001) : (lfsr >> 1);
		end
		return r;
	endfunction

	function automatic dram_data_t fill_word(input dram_addr_t a);
		return a[15:0] ^ {a[20:16], a[20:10]};  // every address bit counts
	endfunction

	function automatic rmode_t expected_render(input vmode_t m);
		case (m)
			mode_16c:  return rend_16c;
			mode_256c: return rend_256c;
			mode_text: return rend_text;
			default:   return rend_zx;  // giga, zxhi, rsvd and nogfx render as zx
		endcase
	endfunction

	function automatic int tiles_for(input rres_t res);
		case (res)
			2'd0:    return 33;
			2'd3:    return 46;
			default: return 41;
		endcase
	endfunction

	// linear modes: page bits, row, column
	function automatic raster_pos_t row_field(input logic wide, input dram_addr_t a);
		return wide ? a[16:8] : a[15:7];
	endfunction

	function automatic col_t col_field(input logic wide, input dram_addr_t a);
		return wide ? a[7:0] : {1'b0, a[6:0]};
	endfunction

	function automatic dram_addr_t linear_addr(input logic wide, input wb_data_t page,
		input raster_pos_t row, input col_t col);
		return wide ? {page[7:4], row, col} : {page[7:3], row, col[6:0]};
	endfunction

	task automatic report_mismatch(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		$display("CHECK FAILED %s got %h expected %h", name, got, exp);
		errors++;
	endtask

	task automatic report_error(input string what);
		$display("ERROR %s", what);
		errors++;
	endtask

	task automatic finish_test(input string name, input int e0);
		tests_run++;
		if (errors == e0) begin
			$display("test %s: ok", name);
		end else begin
			tests_failed++;
			$display("test %s: %0d errors", name, errors - e0);
		end
	endtask

	task automatic next_cycle();
		@(posedge clk);
		#1;  // drive and sample just after the edge
	endtask

	task automatic bus_cycle(input logic we, input wb_addr_t adr, input wb_data_t dw,
		output wb_data_t dr);
		int waited;
		waited = 0;
		wb_cyc = 1'b1;
		wb_stb = 1'b1;
		wb_we = we;
		wb_adr = adr;
		wb_dat_w = dw;
		do begin
			next_cycle();
			waited++;
		end while (!wb_ack && waited < 16);
		dr = wb_dat_r;  // valid while ack is high
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		wb_we = 1'b0;
		if (waited != 1)
			report_error($sformatf("wishbone ack after %0d cycles at address %0d", waited, adr));
		next_cycle();
		if (wb_ack !== 1'b0)
			report_error("wishbone ack stayed high for more than one cycle");
	endtask

	task automatic wb_write(input wb_addr_t adr, input wb_data_t dw);
		wb_data_t unused;
		bus_cycle(1'b1, adr, dw, unused);
	endtask

	task automatic wb_read(input wb_addr_t adr, output wb_data_t dr);
		bus_cycle(1'b0, adr, 8'h00, dr);
	endtask

	// one read: log it, ack after 1 to 4 cycles unless held
	task automatic dram_respond();
		dram_addr_t a;
		int lat;
		while (!dram_req)
			next_cycle();
		a = dram_addr;
		req_addr_q.push_back(a);
		req_bw_q.push_back(dram_bw);
		lat = 1 + int'(rand_bits(2));
		repeat (lat - 1) next_cycle();
		while (hold_ack)
			next_cycle();
		dram_ack = 1'b1;
		dram_data = (char_armed && a == char_addr) ? char_word : fill_word(a);
		next_cycle();
		dram_ack = 1'b0;
	endtask

	task automatic next_request(output dram_addr_t a, output bw_t b, output logic ok);
		int waited;
		waited = 0;
		while (req_addr_q.size() == 0 && waited < 2 * line_clks) begin
			next_cycle();
			waited++;
		end
		ok = (req_addr_q.size() != 0);
		if (ok) begin
			a = req_addr_q.pop_front();
			b = req_bw_q.pop_front();
		end else begin
			report_error("no dram request within two lines");
		end
	endtask

	// returns at the start of window row 0 for resolution 0, before its fetch start
	task automatic wait_first_row();
		int waited;
		waited = 0;
		while (!frame_start && waited < 2 * frame_clks) begin
			next_cycle();
			waited++;
		end
		if (!frame_start)
			report_error("frame_start never came");
		repeat (vbeg_res0 * line_clks) next_cycle();
		req_addr_q.delete();  // leftovers from the blanking lines
		req_bw_q.delete();
	endtask

	task automatic test_registers();
		wb_addr_t regs[4] = '{reg_vconf, reg_vpage, reg_xoffs_lo, reg_xoffs_hi};
		wb_data_t vals[4];
		wb_data_t rd;
		wb_data_t exp;
		int e0;
		e0 = errors;
		if (dram_req !== 1'b0)
			report_mismatch("dram_req", dram_req, 0);
		for (int i = 0; i < 5; i++) begin
			wb_read(wb_addr_t'(i), rd);  // all zero out of reset, status included
			if (rd !== 8'h00)
				report_mismatch("wb_dat_r", rd, 0);
		end
		for (int i = 0; i < 4; i++) begin
			vals[i] = wb_data_t'(rand_bits(8));
			wb_write(regs[i], vals[i]);
		end
		for (int i = 0; i < 4; i++) begin
			wb_read(regs[i], rd);
			exp = (regs[i] == reg_xoffs_hi) ? {7'd0, vals[i][0]} : vals[i];
			if (rd !== exp)
				report_mismatch("wb_dat_r", rd, exp);
		end
		wb_write(wb_addr_t'(5), 8'hff);  // unmapped
		wb_read(wb_addr_t'(5), rd);
		if (rd !== 8'h00)
			report_mismatch("wb_dat_r", rd, 0);
		finish_test("registers", e0);
	endtask

	task automatic test_modes();
		vmode_t m;
		logic exp_hires;
		logic prev;
		int highs;
		int e0;
		e0 = errors;
		for (int i = 0; i < 8; i++) begin
			m = vmode_t'(i);
			exp_hires = (m == mode_text) || (m == mode_zxhi);
			wb_write(reg_vconf, {2'd0, 3'd0, m});
			next_cycle();  // mode register lags vconf
			if (render_mode !== expected_render(m))
				report_mismatch("render_mode", render_mode, expected_render(m));
			if (hires !== exp_hires)
				report_mismatch("hires", hires, exp_hires);
			if (nogfx !== (m == mode_nogfx))
				report_mismatch("nogfx", nogfx, m == mode_nogfx);
			if (m != mode_text && fetch_bsl !== 2'b10)  // graphics modes fetch whole words
				report_mismatch("fetch_bsl", fetch_bsl, 2'b10);
			highs = 0;
			prev = pix_stb;
			for (int c = 0; c < 8; c++) begin
				next_cycle();
				highs += pix_stb;
				if (exp_hires && pix_stb === prev)
					report_error($sformatf("pix_stb not toggling each clk in mode %0d", i));
				prev = pix_stb;
			end
			if (highs != (exp_hires ? 4 : 2))  // f0 on odd phases, q2 on 3 and 7
				report_mismatch("pix_stb high clks per 8", highs, exp_hires ? 4 : 2);
		end
		finish_test("mode outputs", e0);
	endtask

	task automatic test_zx();
		wb_data_t page;
		dram_addr_t a;
		dram_addr_t exp;
		bw_t b;
		logic ok;
		int e0;
		e0 = errors;
		page = wb_data_t'(rand_bits(8));
		wb_write(reg_vconf, {2'd0, 3'd0, mode_zx});
		wb_write(reg_vpage, page);
		wait_first_row();
		for (int i = 0; i < 2; i++) begin
			next_request(a, b, ok);
			exp = (i == 0) ? {page, 13'd0} : {page, 1'b0, 3'b110, 9'd0};  // gfx then attr
			if (ok && a !== exp)
				report_mismatch("dram_addr", a, exp);
			if (ok && b !== 4'b1001)
				report_mismatch("dram_bw", b, 4'b1001);
		end
		finish_test("zx addressing", e0);
	endtask

	task automatic test_linear(input vmode_t m, input rres_t res);
		wb_data_t page;
		dram_addr_t a;
		dram_addr_t exp;
		raster_pos_t row;
		bw_t b;
		logic ok;
		logic wide;
		int n;
		int e0;
		e0 = errors;
		wide = (m == mode_256c);
		page = wb_data_t'(rand_bits(8));
		wb_write(reg_vpage, page);
		wb_write(reg_vconf, {res, 3'd0, m});
		repeat (3 * line_clks) next_cycle();  // a mode switch mid-line can restart a line
		req_addr_q.delete();
		req_bw_q.delete();
		do
			next_request(a, b, ok);
		while (ok && col_field(wide, a) != 8'd0);
		row = row_field(wide, a);
		n = 0;
		while (ok && row_field(wide, a) == row) begin
			exp = linear_addr(wide, page, row, col_t'(n));
			if (a !== exp)
				report_mismatch("dram_addr", a, exp);
			n++;
			next_request(a, b, ok);
		end
		if (wide && n != tiles_for(res))
			report_mismatch("requests per line", n, tiles_for(res));
		if (!wide && (n == 0 || n > tiles_for(res)))
			report_error($sformatf("%0d requests on one 16c row, limit %0d", n, tiles_for(res)));
		finish_test(wide ? "256c addressing" : "16c addressing", e0);
	endtask

	task automatic test_text();
		wb_data_t page;
		dram_addr_t exp[4];
		dram_addr_t a;
		bw_t b;
		logic ok;
		int e0;
		e0 = errors;
		page = wb_data_t'(rand_bits(8));
		char_word = dram_data_t'(rand_bits(16));
		char_addr = {page[7:1], 14'd0};  // char of row 0, column 0
		char_armed = 1'b1;
		wb_write(reg_vpage, page);
		wb_write(reg_vconf, {2'd0, 3'd0, mode_text});
		exp[0] = char_addr;
		exp[1] = {page[7:1], 7'd0, 1'b1, 6'd0};
		exp[2] = {page[7:1], 4'b1000, char_word[7:0], 2'b00};
		exp[3] = {page[7:1], 4'b1000, char_word[15:8], 2'b00};
		wait_first_row();
		for (int i = 0; i < 4; i++) begin
			next_request(a, b, ok);
			if (ok && a !== exp[i])
				report_mismatch("dram_addr", a, exp[i]);
		end
		char_armed = 1'b0;
		finish_test("text addressing", e0);
	endtask

	task automatic test_overrun();
		wb_data_t rd;
		int waited;
		int e0;
		e0 = errors;
		hold_ack = 1'b1;
		waited = 0;
		while (!dram_req && waited < frame_clks) begin
			next_cycle();
			waited++;
		end
		if (!dram_req)
			report_error("no dram request arrived to hold");
		repeat (4 * 16 * 8) next_cycle();  // four text fetch periods
		if (dram_req !== 1'b1)
			report_mismatch("dram_req", dram_req, 1);
		hold_ack = 1'b0;
		wb_read(reg_status, rd);
		if (rd !== 8'h01)
			report_mismatch("wb_dat_r", rd, 8'h01);
		wb_write(reg_status, 8'h00);
		wb_read(reg_status, rd);
		if (rd !== 8'h00)
			report_mismatch("wb_dat_r", rd, 8'h00);
		finish_test("back-pressure", e0);
	endtask

	initial begin
		@(posedge rst_n);
		forever
			dram_respond();
	end

	initial begin
		repeat (6 * frame_clks) @(posedge clk);
		$display("watchdog expired after six frames, tests did not finish");
		$display("Some tests failed");
		$finish;
	end

	initial begin
		rst_n = 1'b0;
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		wb_we = 1'b0;
		wb_adr = '0;
		wb_dat_w = '0;
		dram_ack = 1'b0;
		dram_data = '0;
		repeat (10) @(posedge clk);
		#1;
		rst_n = 1'b1;
		test_registers();
		test_modes();
		test_zx();
		test_linear(mode_16c, 2'd0);
		test_linear(mode_256c, 2'd1);
		test_text();
		test_overrun();
		$display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
		if (tests_failed == 0 && errors == 0)
			$display("All tests passed");
		else
			$display("Some tests failed");
		$finish;
	end

endmodule

//--- sources.f
design/video_cfg_pkg.sv
design/video_bus_pkg.sv
design/video_regs.sv
design/video_mode.sv
design/video_raster.sv
design/video_fetch.sv
design/video_top.sv
bench/video_tb.sv
